//--- hw/rom_macros.svh
`ifndef ROM_MACROS_SVH
`define ROM_MACROS_SVH

// Number of client slots
`define ROM_SLOTS   4

// Address and data widths, in words
`define ROM_AW      18
`define SDRAM_AW    22
`define ROM_DW      16

// Entries in each queue
`define FIFO_DEPTH  4

// Region starts in SDRAM, word addressed
`define MAIN_OFFSET 22'h00_0000
`define SND_OFFSET  22'h04_0000
`define GFX_OFFSET  22'h08_0000
`define PCM_OFFSET  22'h0C_0000

`endif

//--- hw/rom_pkg.sv
`default_nettype none
`include "rom_macros.svh"

package rom_pkg;

// Slot index, also the tag carried by requests and responses
typedef logic [$clog2(`ROM_SLOTS)-1:0] slot_id_t;

// Request towards the SDRAM sequencer
typedef struct packed {
    slot_id_t             tag;
    logic [`SDRAM_AW-1:0] addr;  // Offset already added
} rom_req_t;

// Word returned to the slots
typedef struct packed {
    slot_id_t           tag;
    logic [`ROM_DW-1:0] data;
} rom_resp_t;

endpackage

`default_nettype wire

//--- hw/req_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module req_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  item_t in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_data
);

localparam int PW = DEPTH > 1 ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

item_t         mem [DEPTH];
logic [PW-1:0] wr_ptr;
logic [PW-1:0] rd_ptr;
logic [CW-1:0] count;
logic          push;
logic          pop;

function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

assign in_ready  = count != CW'(DEPTH);
assign out_valid = count != '0;
assign out_data  = mem[rd_ptr];    // Head shows the cycle after a push
assign push      = in_valid && in_ready;
assign pop       = out_valid && out_ready;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) wr_ptr <= next_ptr(wr_ptr);
        if (pop)  rd_ptr <= next_ptr(rd_ptr);
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or push with pop
        endcase
    end
end

always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
end

endmodule

`default_nettype wire

//--- hw/rom_slot.sv
`timescale 1ns/100ps
`default_nettype none
`include "rom_macros.svh"

module rom_slot
    import rom_pkg::*;
#(
    parameter logic [`SDRAM_AW-1:0] OFFSET  = '0,  // Region start in SDRAM
    parameter slot_id_t             SLOT_ID = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    // Client side
    input  logic               cs,
    input  logic [`ROM_AW-1:0] addr,
    output logic [`ROM_DW-1:0] data,
    output logic               ok,
    // Towards the arbiter
    output logic               req_valid,
    output rom_req_t           req,
    input  logic               grant,
    // Response broadcast
    input  logic               resp_valid,
    input  rom_resp_t          resp
);

logic [`ROM_AW-1:0] cache_addr;
logic [`ROM_DW-1:0] cache_data;
logic               cache_valid;
logic [`ROM_AW-1:0] pend_addr;   // Address of the request in flight
logic               pending;
logic               hit;
logic               resp_mine;
logic               store;

assign hit       = cache_valid && cache_addr == addr;
assign ok        = cs && hit;
assign data      = cache_data;

// One request in flight at most
assign req_valid = cs && !hit && !pending;
assign req.tag   = SLOT_ID;
assign req.addr  = `SDRAM_AW'(addr) + OFFSET;

assign resp_mine = resp_valid && pending && resp.tag == SLOT_ID;
// A word for an address the client has left is dropped
assign store     = resp_mine && pend_addr == addr;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pending     <= 1'b0;
        cache_valid <= 1'b0;
    end else begin
        if (grant) begin
            pending <= 1'b1;
        end else if (resp_mine) begin
            pending <= 1'b0;
        end
        if (store) begin
            cache_valid <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (grant) begin
        pend_addr <= addr;  // Client holds addr until ok
    end
    if (store) begin
        cache_addr <= addr;
        cache_data <= resp.data;
    end
end

endmodule

`default_nettype wire

//--- hw/slot_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "rom_macros.svh"

module slot_arbiter
    import rom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Slot requests
    input  logic [`ROM_SLOTS-1:0] req_valid,
    input  rom_req_t              req [`ROM_SLOTS],
    output logic [`ROM_SLOTS-1:0] grant,
    // Towards the request queue
    output logic                  out_valid,
    output rom_req_t              out,
    input  logic                  out_ready
);

slot_id_t              last;      // Slot served most recently
slot_id_t              sel_id;
logic                  sel_found;
logic                  load;
logic [`ROM_SLOTS-1:0] cand;

// The slot granted last cycle only marks itself pending now
assign cand = req_valid & ~grant;
assign load = sel_found && (!out_valid || out_ready);

// Search starts right after the last slot served
always_comb begin
    slot_id_t idx;
    sel_found = 1'b0;
    sel_id    = last;
    for (int i = 1; i <= `ROM_SLOTS; i++) begin
        idx = slot_id_t'((int'(last) + i) % `ROM_SLOTS);
        if (!sel_found && cand[idx]) begin
            sel_found = 1'b1;
            sel_id    = idx;
        end
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        last      <= slot_id_t'(`ROM_SLOTS - 1);  // Slot 0 goes first
        grant     <= '0;
        out_valid <= 1'b0;
    end else begin
        grant <= '0;
        if (load) begin
            grant[sel_id] <= 1'b1;
            last          <= sel_id;
            out_valid     <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (load) begin
        out <= req[sel_id];
    end
end

endmodule

`default_nettype wire

//--- hw/sdram_seq.sv
`timescale 1ns/100ps
`default_nettype none
`include "rom_macros.svh"

module sdram_seq
    import rom_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    // Request queue
    input  logic                 req_valid,
    output logic                 req_ready,
    input  rom_req_t             req,
    // Response queue
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output rom_resp_t            resp,
    // SDRAM controller
    output logic                 sdram_req,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [`ROM_DW-1:0]   data_read
);

typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_DATA,
    PUSH
} state_t;

state_t             state;
slot_id_t           cur_tag;   // Owner of the access in progress
logic [`ROM_DW-1:0] rd_data;

// No pop unless the response has somewhere to go
assign req_ready  = state == IDLE && resp_ready;
assign resp_valid = state == PUSH;
assign resp.tag   = cur_tag;
assign resp.data  = rd_data;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state     <= IDLE;
        sdram_req <= 1'b0;
    end else begin
        case (state)
            IDLE: if (req_valid && req_ready) begin
                sdram_req <= 1'b1;
                state     <= REQ;
            end
            REQ: if (sdram_ack) begin
                sdram_req <= 1'b0;   // Controller has latched the address
                state     <= WAIT_DATA;
            end
            WAIT_DATA: if (data_rdy) begin
                state <= PUSH;
            end
            PUSH: if (resp_ready) begin
                state <= IDLE;
            end
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == IDLE && req_valid && req_ready) begin
        cur_tag    <= req.tag;
        sdram_addr <= req.addr;
    end
    if (state == WAIT_DATA && data_rdy) begin
        rd_data <= data_read;
    end
end

endmodule

`default_nettype wire

//--- hw/rom_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "rom_macros.svh"

module rom_fetch_top
    import rom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Game side slots
    input  logic [`ROM_SLOTS-1:0] slot_cs,
    input  logic [`ROM_AW-1:0]    slot_addr [`ROM_SLOTS],
    output logic [`ROM_DW-1:0]    slot_data [`ROM_SLOTS],
    output logic [`ROM_SLOTS-1:0] slot_ok,
    // SDRAM controller
    output logic                  sdram_req,
    output logic [`SDRAM_AW-1:0]  sdram_addr,
    input  logic                  sdram_ack,
    input  logic                  data_rdy,
    input  logic [`ROM_DW-1:0]    data_read
);

// Main, sound, graphics, ADPCM
localparam logic [`SDRAM_AW-1:0] OFFSETS [`ROM_SLOTS] = '{
    `MAIN_OFFSET, `SND_OFFSET, `GFX_OFFSET, `PCM_OFFSET
};

logic [`ROM_SLOTS-1:0] slot_req_valid;
rom_req_t              slot_req [`ROM_SLOTS];
logic [`ROM_SLOTS-1:0] grant;
logic                  arb_valid;
logic                  arb_ready;
rom_req_t              arb_req;
logic                  q_valid;
logic                  q_ready;
rom_req_t              q_req;
logic                  seq_valid;
logic                  seq_ready;
rom_resp_t             seq_resp;
logic                  resp_valid;
rom_resp_t             resp;

for (genvar i = 0; i < `ROM_SLOTS; i++) begin : g_slot
    rom_slot #(
        .OFFSET     ( OFFSETS[i]        ),
        .SLOT_ID    ( slot_id_t'(i)     )
    ) u_slot (
        .clk        ( clk               ),
        .rst_n      ( rst_n             ),
        .cs         ( slot_cs[i]        ),
        .addr       ( slot_addr[i]      ),
        .data       ( slot_data[i]      ),
        .ok         ( slot_ok[i]        ),
        .req_valid  ( slot_req_valid[i] ),
        .req        ( slot_req[i]       ),
        .grant      ( grant[i]          ),
        .resp_valid ( resp_valid        ),
        .resp       ( resp              )
    );
end

slot_arbiter u_arb (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .req_valid  ( slot_req_valid ),
    .req        ( slot_req       ),
    .grant      ( grant          ),
    .out_valid  ( arb_valid      ),
    .out        ( arb_req        ),
    .out_ready  ( arb_ready      )
);

req_fifo #(
    .item_t     ( rom_req_t      ),
    .DEPTH      ( `FIFO_DEPTH    )
) u_req_q (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .in_valid   ( arb_valid      ),
    .in_ready   ( arb_ready      ),
    .in_data    ( arb_req        ),
    .out_valid  ( q_valid        ),
    .out_ready  ( q_ready        ),
    .out_data   ( q_req          )
);

sdram_seq u_seq (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .req_valid  ( q_valid        ),
    .req_ready  ( q_ready        ),
    .req        ( q_req          ),
    .resp_valid ( seq_valid      ),
    .resp_ready ( seq_ready      ),
    .resp       ( seq_resp       ),
    .sdram_req  ( sdram_req      ),
    .sdram_addr ( sdram_addr     ),
    .sdram_ack  ( sdram_ack      ),
    .data_rdy   ( data_rdy       ),
    .data_read  ( data_read      )
);

req_fifo #(
    .item_t     ( rom_resp_t     ),
    .DEPTH      ( `FIFO_DEPTH    )
) u_resp_q (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .in_valid   ( seq_valid      ),
    .in_ready   ( seq_ready      ),
    .in_data    ( seq_resp       ),
    .out_valid  ( resp_valid     ),
    .out_ready  ( 1'b1           ),  // Owner slot always takes its word
    .out_data   ( resp           )
);

endmodule

`default_nettype wire

//--- test/rom_fetch_sva.sv
`timescale 1ns/100ps
`default_nettype none
`include "rom_macros.svh"

module rom_fetch_sva
    import rom_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 sdram_req,
    input logic [`SDRAM_AW-1:0] sdram_addr,
    input logic                 sdram_ack,
    input logic                 resp_valid,
    input logic                 resp_ready,
    input rom_resp_t            resp
);

// Controller must see the request until it acknowledges
req_held: assert property (@(posedge clk) disable iff (!rst_n)
    sdram_req && !sdram_ack |=> sdram_req)
    else $error("sdram_req dropped before sdram_ack");

addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sdram_req && !sdram_ack |=> $stable(sdram_addr))
    else $error("sdram_addr changed during a request");

// A full response queue stalls the word in place
resp_held: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else $error("response lost while resp_ready was low");

endmodule

bind sdram_seq rom_fetch_sva u_sva (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .sdram_req  ( sdram_req  ),
    .sdram_addr ( sdram_addr ),
    .sdram_ack  ( sdram_ack  ),
    .resp_valid ( resp_valid ),
    .resp_ready ( resp_ready ),
    .resp       ( resp       )
);

`default_nettype wire

//--- test/rom_fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "rom_macros.svh"

module rom_fetch_tb;

localparam int READ_LIMIT = 400;  // Cycles a client waits for ok
localparam logic [1:0] M_IDLE = 2'd0;
localparam logic [1:0] M_ACK  = 2'd1;
localparam logic [1:0] M_DATA = 2'd2;
localparam logic [`SDRAM_AW-1:0] OFFSETS [`ROM_SLOTS] = '{
    `MAIN_OFFSET, `SND_OFFSET, `GFX_OFFSET, `PCM_OFFSET
};

logic                  clk = 1'b0;
logic                  rst_n = 1'b0;
logic [`ROM_SLOTS-1:0] slot_cs;
logic [`ROM_AW-1:0]    slot_addr [`ROM_SLOTS];
logic [`ROM_DW-1:0]    slot_data [`ROM_SLOTS];
logic [`ROM_SLOTS-1:0] slot_ok;
logic                  sdram_req;
logic [`SDRAM_AW-1:0]  sdram_addr;
logic                  sdram_ack = 1'b0;
logic                  data_rdy = 1'b0;
logic [`ROM_DW-1:0]    data_read = '0;

// SDRAM model state
logic [1:0]           mstate = M_IDLE;
logic [2:0]           delay = '0;
logic [`SDRAM_AW-1:0] last_addr = '0;
logic [31:0]          model_rng = 32'd30;
int                   txn_count = 0;
logic                 slow = 1'b0;  // Longest ack and data delays

logic [31:0]        rng [`ROM_SLOTS];  // One stream per client
logic [`ROM_AW-1:0] first_addr [`ROM_SLOTS];
int                 checks = 0;
int                 errors = 0;
int                 mark = 0;
int                 test_num = 0;
logic               timed_out = 1'b0;

rom_fetch_top UUT (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .slot_cs    ( slot_cs    ),
    .slot_addr  ( slot_addr  ),
    .slot_data  ( slot_data  ),
    .slot_ok    ( slot_ok    ),
    .sdram_req  ( sdram_req  ),
    .sdram_addr ( sdram_addr ),
    .sdram_ack  ( sdram_ack  ),
    .data_rdy   ( data_rdy   ),
    .data_read  ( data_read  )
);

always #4 clk = ~clk;

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] draw(input int idx);
    rng[idx] = xorshift(rng[idx]);
    return rng[idx];
endfunction

// ROM contents as stored in SDRAM
function automatic logic [`ROM_DW-1:0] model_word(input logic [`SDRAM_AW-1:0] a);
    return a[15:0] ^ 16'hC35A;
endfunction

function automatic logic [`ROM_DW-1:0] expect_word(input int s, input logic [`ROM_AW-1:0] a);
    return model_word(OFFSETS[s] + `SDRAM_AW'(a));
endfunction

// Answers one request at a time with random ack and data delays
always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        mstate    <= M_IDLE;
        delay     <= '0;
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        data_read <= '0;
    end else begin
        sdram_ack <= 1'b0;  // Single-cycle pulses
        data_rdy  <= 1'b0;
        case (mstate)
            M_IDLE: if (sdram_req) begin
                model_rng  = xorshift(model_rng);
                last_addr <= sdram_addr;
                txn_count <= txn_count + 1;
                delay     <= slow ? 3'd5 : 3'(model_rng % 6);
                mstate    <= M_ACK;
            end
            M_ACK: if (delay == 3'd0) begin
                model_rng  = xorshift(model_rng);
                sdram_ack <= 1'b1;
                delay     <= slow ? 3'd3 : 3'(model_rng % 4);
                mstate    <= M_DATA;
            end else begin
                delay <= delay - 3'd1;
            end
            M_DATA: if (delay == 3'd0) begin
                data_rdy  <= 1'b1;
                data_read <= model_word(last_addr);
                mstate    <= M_IDLE;
            end else begin
                delay <= delay - 3'd1;
            end
            default: mstate <= M_IDLE;
        endcase
    end
end

task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

// Holds cs and addr until ok and returns the word and the SDRAM accesses seen
task automatic read_word(input int s, input logic [`ROM_AW-1:0] a,
                         output logic [`ROM_DW-1:0] d, output int cyc, output int txns);
    int start;
    @(posedge clk);
    slot_cs[s]   <= 1'b1;
    slot_addr[s] <= a;
    start = txn_count;
    cyc   = 0;
    d     = 'x;
    @(negedge clk);
    while (!slot_ok[s] && cyc < READ_LIMIT) begin
        cyc++;
        @(negedge clk);
    end
    if (slot_ok[s]) begin
        d = slot_data[s];
    end else begin
        timed_out = 1'b1;
        $display("slot %0d got no ok for address %h within %0d cycles", s, a, READ_LIMIT);
    end
    txns = txn_count - start;
    @(posedge clk);
    slot_cs[s] <= 1'b0;
endtask

task automatic run_client(input int s, input int n, input logic fair);
    logic [`ROM_AW-1:0] a;
    logic [`ROM_DW-1:0] d;
    int                 cyc;
    int                 txns;
    for (int i = 0; i < n; i++) begin
        a = `ROM_AW'(draw(s));
        read_word(s, a, d, cyc, txns);
        check_eq($sformatf("slot %0d data at %h", s, a), 32'(d), 32'(expect_word(s, a)));
        if (fair) begin
            check_eq($sformatf("slot %0d served within 4 accesses (took %0d)", s, txns),
                     32'(txns <= 4), 32'd1);
        end
    end
endtask

task automatic finish_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, errors - mark);
    mark = errors;
endtask

initial begin
    logic [`ROM_DW-1:0] d;
    int                 cyc;
    int                 txns;
    int                 base;
    slot_cs = '0;
    for (int s = 0; s < `ROM_SLOTS; s++) begin
        slot_addr[s] = '0;
    end
    rng[0] = xorshift(32'd30);
    for (int s = 1; s < `ROM_SLOTS; s++) begin
        rng[s] = xorshift(rng[s-1]);
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int s = 0; s < `ROM_SLOTS; s++) begin
        first_addr[s] = `ROM_AW'(draw(s));
        read_word(s, first_addr[s], d, cyc, txns);
        check_eq($sformatf("slot %0d miss data", s), 32'(d), 32'(expect_word(s, first_addr[s])));
        check_eq($sformatf("slot %0d sdram_addr", s), 32'(last_addr),
                 32'(OFFSETS[s] + `SDRAM_AW'(first_addr[s])));
    end
    finish_test("single miss");

    // Cache still holds each slot's first word
    for (int s = 0; s < `ROM_SLOTS; s++) begin
        base = txn_count;
        read_word(s, first_addr[s], d, cyc, txns);
        check_eq($sformatf("slot %0d hit data", s), 32'(d), 32'(expect_word(s, first_addr[s])));
        check_eq($sformatf("slot %0d hit latency", s), 32'(cyc), 32'd0);
        repeat (8) @(negedge clk);  // Long enough for a stray request to reach the SDRAM
        check_eq($sformatf("slot %0d hit accesses", s), 32'(txn_count - base), 32'd0);
    end
    finish_test("hit");

    fork
        run_client(0, 1, 1'b0);
        run_client(1, 1, 1'b0);
        run_client(2, 1, 1'b0);
        run_client(3, 1, 1'b0);
    join
    finish_test("concurrent slots");

    fork
        run_client(0, 12, 1'b1);
        run_client(1, 12, 1'b1);
        run_client(2, 12, 1'b1);
        run_client(3, 12, 1'b1);
    join
    finish_test("fairness");

    @(negedge clk);
    slow = 1'b1;
    fork
        run_client(0, 50, 1'b0);
        run_client(1, 50, 1'b0);
        run_client(2, 50, 1'b0);
        run_client(3, 50, 1'b0);
    join
    @(negedge clk);
    slow = 1'b0;
    finish_test("slow sdram");

    // Reset lands mid-fetch while slot 0 sits on a cached word
    read_word(0, first_addr[0], d, cyc, txns);
    @(posedge clk);
    slot_cs[0]   <= 1'b1;
    slot_addr[0] <= first_addr[0];
    slot_cs[1]   <= 1'b1;
    slot_addr[1] <= `ROM_AW'(draw(1));
    cyc = 0;
    @(negedge clk);
    while (!sdram_req && cyc < READ_LIMIT) begin
        cyc++;
        @(negedge clk);
    end
    if (!sdram_req) begin
        timed_out = 1'b1;
        $display("no sdram_req appeared within %0d cycles before reset", READ_LIMIT);
    end
    check_eq("slot 0 ok before reset", 32'(slot_ok[0]), 32'd1);
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("sdram_req after reset", 32'(sdram_req), 32'd0);
    check_eq("slot_ok after reset", 32'(slot_ok), 32'd0);
    @(posedge clk);
    slot_cs <= '0;
    finish_test("reset");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
        $display(">>> PASS");
    end else begin
        $display(">>> FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/rom_pkg.sv
hw/req_fifo.sv
hw/rom_slot.sv
hw/slot_arbiter.sv
hw/sdram_seq.sv
hw/rom_fetch_top.sv
test/rom_fetch_sva.sv
test/rom_fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line appears
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
    --top-module rom_fetch_tb -f compile.f -o rom_fetch_sim \
    && ./obj_dir/rom_fetch_sim | tee /dev/stderr | grep -qF ">>> PASS" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
